// File: rename_defs.svh
/*
 * size macros for the integer register rename stage
 * lanes, architectural and physical register counts,
 * free-list depth, branch snapshot count and derived widths
 */

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// --------------------------------------------------
// group and register file sizes
// --------------------------------------------------
`define RN_DISP_SIZE   2    // lanes per dispatch group
`define RN_NUM_ARCH    32   // x0 .. x31
`define RN_FLIST_SIZE  16   // free ids held by each lane

// arch regs plus one free list per lane
`define RN_NUM_PHYS    64

// --------------------------------------------------
// branch recovery
// --------------------------------------------------
`define RN_NUM_SNAP    4    // snapshot slots, one per branch tag

// --------------------------------------------------
// derived widths
// --------------------------------------------------
`define RN_RNID_W      $clog2(`RN_NUM_PHYS)
`define RN_ARCH_W      $clog2(`RN_NUM_ARCH)
`define RN_BRTAG_W     $clog2(`RN_NUM_SNAP)
`define RN_FPTR_W      $clog2(`RN_FLIST_SIZE)

`endif

// File: rename_types_pkg.sv
/*
 * id types for the rename stage
 * per-lane front end and dispatch structs
 */

`default_nettype none

package rename_types_pkg;

`include "rename_defs.svh"

  // --------------------------------------------------
  // id words
  // --------------------------------------------------
  typedef logic [`RN_RNID_W-1:0]  rnid_t;     // physical register id
  typedef logic [`RN_ARCH_W-1:0]  arch_id_t;  // architectural index
  typedef logic [`RN_BRTAG_W-1:0] brtag_t;    // snapshot slot

  // one lane coming from the front end
  typedef struct packed {
    logic     valid;
    logic     wr_en;      // instruction writes rd
    arch_id_t rd;
    logic     rs1_valid;
    arch_id_t rs1;
    logic     rs2_valid;
    arch_id_t rs2;
    logic     is_br;      // take a map snapshot for this lane
  } front_inst_t;

  // one renamed lane towards dispatch
  typedef struct packed {
    logic  valid;
    rnid_t rd_id;    // newly allocated
    rnid_t old_id;   // previous mapping of rd, freed at commit
    rnid_t rs1_id;
    rnid_t rs2_id;
  } disp_inst_t;

endpackage

`default_nettype wire

// File: rename_event_pkg.sv
/*
 * commit and branch update events
 * commit kind enum
 */

`default_nettype none

package rename_event_pkg;

`include "rename_defs.svh"

  typedef enum logic {
    CMT_LIVE = 1'b0,  // retired normally, old id is free
    CMT_DEAD = 1'b1   // squashed, new id goes back
  } cmt_kind_e;

  typedef struct packed {
    logic                      valid;
    cmt_kind_e                 kind;
    rename_types_pkg::arch_id_t rd;
    rename_types_pkg::rnid_t    new_id;
    rename_types_pkg::rnid_t    old_id;
  } cmt_lane_t;

  typedef struct packed {
    logic                     valid;
    logic                     mispredict;
    logic                     dead;       // branch itself was flushed
    rename_types_pkg::brtag_t tag;
  } br_upd_t;

endpackage

`default_nettype wire

// File: rename_freelist.sv
/*
 * free list of physical ids for one dispatch lane
 * circular FIFO, commit lane registered once before the push
 */

`default_nettype none

`include "rename_defs.svh"

module rename_freelist #(
  parameter rename_types_pkg::rnid_t INIT_BASE = '0
) (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset_n,
  input  wire logic                        i_pop,
  input  wire rename_event_pkg::cmt_lane_t i_commit,
  output rename_types_pkg::rnid_t          o_pop_id,
  output logic                             o_empty
);

  import rename_types_pkg::*;
  import rename_event_pkg::*;

  localparam int DEPTH = `RN_FLIST_SIZE;
  localparam int PTR_W = `RN_FPTR_W;
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(DEPTH);

  rnid_t            r_list [DEPTH];
  logic [PTR_W-1:0] r_rd_ptr;
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W:0]   r_count;
  cmt_lane_t        r_cmt;      // commit lane, one cycle late

  logic  w_push;
  rnid_t w_push_id;

  // --------------------------------------------------
  // return path
  // --------------------------------------------------
  assign w_push    = r_cmt.valid && (r_cmt.rd != '0);   // x0 never owned an id
  assign w_push_id = (r_cmt.kind == CMT_DEAD) ? r_cmt.new_id : r_cmt.old_id;

  assign o_pop_id = r_list[r_rd_ptr];
  assign o_empty  = (r_count == '0);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cmt    <= '0;
      r_rd_ptr <= '0;
      r_wr_ptr <= '0;
      r_count  <= FULL_CNT;     // starts full
      for (int i = 0; i < DEPTH; i++) begin
        r_list[i] <= INIT_BASE + rnid_t'(i);
      end
    end else begin
      r_cmt <= i_commit;
      if (w_push) begin
        r_list[r_wr_ptr] <= w_push_id;
        r_wr_ptr         <= r_wr_ptr + PTR_W'(1);
      end
      if (i_pop) begin
        r_rd_ptr <= r_rd_ptr + PTR_W'(1);
      end
      case ({w_push, i_pop})
        2'b10:   r_count <= r_count + (PTR_W+1)'(1);
        2'b01:   r_count <= r_count - (PTR_W+1)'(1);
        default: r_count <= r_count;
      endcase
    end
  end

  // fire must wait for o_freelist_ready at the top
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> !o_empty);

  // more returns than allocations means an id was freed twice
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_push |-> (r_count != FULL_CNT));

endmodule

`default_nettype wire

// File: rename_map_table.sv
/*
 * architectural to physical map for the integer registers
 * source and old-rd lookup per lane, in-order writes on fire,
 * whole-map restore from a branch snapshot
 */

`default_nettype none

`include "rename_defs.svh"

module rename_map_table (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset_n,
  input  wire rename_types_pkg::front_inst_t i_front       [`RN_DISP_SIZE],
  input  wire logic                          i_fire,
  input  wire rename_types_pkg::rnid_t       i_new_id      [`RN_DISP_SIZE],
  input  wire logic                          i_restore,
  input  wire rename_types_pkg::rnid_t       i_restore_map [`RN_NUM_ARCH],
  output rename_types_pkg::rnid_t            o_rs1_id      [`RN_DISP_SIZE],
  output rename_types_pkg::rnid_t            o_rs2_id      [`RN_DISP_SIZE],
  output rename_types_pkg::rnid_t            o_old_id      [`RN_DISP_SIZE],
  output rename_types_pkg::rnid_t            o_map         [`RN_NUM_ARCH]
);

  import rename_types_pkg::*;

  rnid_t r_map [`RN_NUM_ARCH];
  logic  w_wr  [`RN_DISP_SIZE];

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  // raw map values, the in-group overrides happen in the bypass
  always_comb begin
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      o_rs1_id[d] = r_map[i_front[d].rs1];
      o_rs2_id[d] = r_map[i_front[d].rs2];
      o_old_id[d] = r_map[i_front[d].rd];
      w_wr[d]     = i_fire && i_front[d].valid && i_front[d].wr_en &&
                    (i_front[d].rd != '0);
    end
  end

  assign o_map = r_map;

  // --------------------------------------------------
  // update
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `RN_NUM_ARCH; i++) begin
        r_map[i] <= rnid_t'(i);   // identity
      end
    end else if (i_restore) begin
      // mispredict recovery beats any write in this cycle
      for (int i = 0; i < `RN_NUM_ARCH; i++) begin
        r_map[i] <= i_restore_map[i];
      end
    end else begin
      // lane order, so a later lane to the same rd wins
      for (int d = 0; d < `RN_DISP_SIZE; d++) begin
        if (w_wr[d]) begin
          r_map[i_front[d].rd] <= i_new_id[d];
        end
      end
    end
  end

  // snapshots and lane writes both have to keep x0 on id 0
  a_x0_fixed: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_map[0] == '0);

endmodule

`default_nettype wire

// File: rename_snapshot_queue.sv
/*
 * per-branch-tag copies of the rename map
 * each copy includes the group writes up to the branch lane
 */

`default_nettype none

`include "rename_defs.svh"

module rename_snapshot_queue (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset_n,
  input  wire rename_types_pkg::rnid_t       i_map         [`RN_NUM_ARCH],
  input  wire rename_types_pkg::front_inst_t i_front       [`RN_DISP_SIZE],
  input  wire logic                          i_fire,
  input  wire rename_types_pkg::rnid_t       i_new_id      [`RN_DISP_SIZE],
  input  wire rename_types_pkg::brtag_t      i_brtag       [`RN_DISP_SIZE],
  input  wire rename_event_pkg::br_upd_t     i_br_upd,
  output logic                               o_restore,
  output rename_types_pkg::rnid_t            o_restore_map [`RN_NUM_ARCH]
);

  import rename_types_pkg::*;

  rnid_t                   r_snap     [`RN_NUM_SNAP][`RN_NUM_ARCH];
  logic [`RN_NUM_SNAP-1:0] r_snap_vld;  // slot written since reset
  rnid_t                   w_lane_map [`RN_DISP_SIZE][`RN_NUM_ARCH];

  // --------------------------------------------------
  // map as seen just after each lane
  // --------------------------------------------------
  always_comb begin
    rnid_t v_map [`RN_NUM_ARCH];
    v_map = i_map;
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      if (i_front[d].valid && i_front[d].wr_en && (i_front[d].rd != '0)) begin
        v_map[i_front[d].rd] = i_new_id[d];
      end
      w_lane_map[d] = v_map;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      if (i_fire && i_front[d].valid && i_front[d].is_br) begin
        r_snap[i_brtag[d]] <= w_lane_map[d];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_snap_vld <= '0;
    end else begin
      for (int d = 0; d < `RN_DISP_SIZE; d++) begin
        if (i_fire && i_front[d].valid && i_front[d].is_br) begin
          r_snap_vld[i_brtag[d]] <= 1'b1;
        end
      end
    end
  end

  assign o_restore     = i_br_upd.valid && i_br_upd.mispredict && !i_br_upd.dead;
  assign o_restore_map = r_snap[i_br_upd.tag];

  // the tag of a mispredict must belong to a branch seen earlier
  a_restore_stored: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_restore |-> r_snap_vld[i_br_upd.tag]);

endmodule

`default_nettype wire

// File: rename_dep_bypass.sv
/*
 * in-group forwarding of freshly allocated ids
 * later lanes take the new id of the nearest earlier writer
 */

`default_nettype none

`include "rename_defs.svh"

module rename_dep_bypass (
  input  wire rename_types_pkg::front_inst_t i_front  [`RN_DISP_SIZE],
  input  wire rename_types_pkg::rnid_t       i_new_id [`RN_DISP_SIZE],
  input  wire rename_types_pkg::rnid_t       i_rs1_id [`RN_DISP_SIZE],
  input  wire rename_types_pkg::rnid_t       i_rs2_id [`RN_DISP_SIZE],
  input  wire rename_types_pkg::rnid_t       i_old_id [`RN_DISP_SIZE],
  output rename_types_pkg::disp_inst_t       o_disp   [`RN_DISP_SIZE]
);

  import rename_types_pkg::*;

  rnid_t w_rd_id [`RN_DISP_SIZE];
  logic  w_wr    [`RN_DISP_SIZE];

  // x0 writes carry id 0, and so does a lane without rd
  always_comb begin
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      w_wr[d]    = i_front[d].valid && i_front[d].wr_en;
      w_rd_id[d] = (w_wr[d] && (i_front[d].rd != '0)) ? i_new_id[d] : '0;
    end
  end

  for (genvar d = 0; d < `RN_DISP_SIZE; d++) begin : g_lane
    always_comb begin
      rnid_t v_rs1;
      rnid_t v_rs2;
      rnid_t v_old;
      v_rs1 = i_rs1_id[d];
      v_rs2 = i_rs2_id[d];
      v_old = i_old_id[d];
      // ascending scan, nearest earlier writer ends up on top
      for (int p = 0; p < d; p++) begin
        if (w_wr[p] && (i_front[p].rd == i_front[d].rs1)) v_rs1 = w_rd_id[p];
        if (w_wr[p] && (i_front[p].rd == i_front[d].rs2)) v_rs2 = w_rd_id[p];
        if (w_wr[p] && (i_front[p].rd == i_front[d].rd))  v_old = w_rd_id[p];
      end

      o_disp[d].valid  = i_front[d].valid;
      o_disp[d].rd_id  = w_rd_id[d];
      o_disp[d].old_id = i_front[d].wr_en     ? v_old : '0;
      o_disp[d].rs1_id = i_front[d].rs1_valid ? v_rs1 : '0;
      o_disp[d].rs2_id = i_front[d].rs2_valid ? v_rs2 : '0;
    end
  end

endmodule

`default_nettype wire

// File: rename_unit.sv
/*
 * rename stage top for the integer register file
 * per-lane free lists, map table, branch snapshots, group bypass
 */

`default_nettype none

`include "rename_defs.svh"

module rename_unit (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset_n,
  input  wire logic                          i_front_fire,
  input  wire rename_types_pkg::front_inst_t i_front  [`RN_DISP_SIZE],
  input  wire rename_types_pkg::brtag_t      i_brtag  [`RN_DISP_SIZE],
  input  wire rename_event_pkg::cmt_lane_t   i_commit [`RN_DISP_SIZE],
  input  wire rename_event_pkg::br_upd_t     i_br_upd,
  output logic                               o_freelist_ready,
  output rename_types_pkg::disp_inst_t       o_disp   [`RN_DISP_SIZE]
);

  import rename_types_pkg::*;

  logic [`RN_DISP_SIZE-1:0] w_empty;
  logic                     w_pop       [`RN_DISP_SIZE];
  rnid_t                    w_pop_id    [`RN_DISP_SIZE];
  rnid_t                    w_rs1_id    [`RN_DISP_SIZE];
  rnid_t                    w_rs2_id    [`RN_DISP_SIZE];
  rnid_t                    w_old_id    [`RN_DISP_SIZE];
  rnid_t                    w_map       [`RN_NUM_ARCH];
  rnid_t                    w_restore_map [`RN_NUM_ARCH];
  logic                     w_restore;

  assign o_freelist_ready = ~|w_empty;

  // --------------------------------------------------
  // one free list per lane
  // --------------------------------------------------
  for (genvar d = 0; d < `RN_DISP_SIZE; d++) begin : g_flist
    assign w_pop[d] = i_front_fire && i_front[d].valid && i_front[d].wr_en &&
                      (i_front[d].rd != '0);

    rename_freelist #(
      .INIT_BASE (rnid_t'(`RN_NUM_ARCH + `RN_FLIST_SIZE * d))
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_pop     (w_pop[d]),
      .i_commit  (i_commit[d]),
      .o_pop_id  (w_pop_id[d]),
      .o_empty   (w_empty[d])
    );
  end

  rename_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_front       (i_front),
    .i_fire        (i_front_fire),
    .i_new_id      (w_pop_id),
    .i_restore     (w_restore),
    .i_restore_map (w_restore_map),
    .o_rs1_id      (w_rs1_id),
    .o_rs2_id      (w_rs2_id),
    .o_old_id      (w_old_id),
    .o_map         (w_map)
  );

  rename_snapshot_queue u_snapshot_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_map         (w_map),
    .i_front       (i_front),
    .i_fire        (i_front_fire),
    .i_new_id      (w_pop_id),
    .i_brtag       (i_brtag),
    .i_br_upd      (i_br_upd),
    .o_restore     (w_restore),
    .o_restore_map (w_restore_map)
  );

  rename_dep_bypass u_dep_bypass (
    .i_front  (i_front),
    .i_new_id (w_pop_id),
    .i_rs1_id (w_rs1_id),
    .i_rs2_id (w_rs2_id),
    .i_old_id (w_old_id),
    .o_disp   (o_disp)
  );

endmodule

`default_nettype wire

// File: rename_tb_clock.sv
/*
 * testbench clock and reset
 * free-running clock, active-low reset held for a set number of cycles
 */

`default_nettype none

module rename_tb_clock #(
  parameter int HALF_PERIOD  = 2,   // period of 4
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset_n = 1'b1;   // released between edges
  end

endmodule

`default_nettype wire

// File: rename_tb.sv
/*
 * testbench for the integer register rename stage
 * replays rename_stimulus.txt with dispatch groups, look-ups,
 * commit lanes, branch updates and ready checks
 */

`default_nettype none

`include "rename_defs.svh"

module rename_tb;

  import rename_types_pkg::*;
  import rename_event_pkg::*;

  localparam int WAIT_LIMIT = 64;                      // cycles allowed per wait
  localparam int LANE_W     = $clog2(`RN_DISP_SIZE);
  localparam int GROUP_COLS = 1 + 13 * `RN_DISP_SIZE;  // rep, lane fields, expected ids

  logic        clk;
  logic        reset_n;
  logic        front_fire;
  front_inst_t front  [`RN_DISP_SIZE];
  brtag_t      brtag  [`RN_DISP_SIZE];
  cmt_lane_t   commit [`RN_DISP_SIZE];
  br_upd_t     br_upd;
  logic        freelist_ready;
  disp_inst_t  disp   [`RN_DISP_SIZE];

  int    fields [$];   // hex columns of the current line
  string id_names [4] = '{"rd_id", "old_id", "rs1_id", "rs2_id"};
  int    line_no;
  int    errors;
  int    checks;
  logic  aborted;

  rename_tb_clock #(
    .HALF_PERIOD  (2),
    .RESET_CYCLES (8)
  ) u_clock (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  rename_unit i_dut (
    .i_clk            (clk),
    .i_reset_n        (reset_n),
    .i_front_fire     (front_fire),
    .i_front          (front),
    .i_brtag          (brtag),
    .i_commit         (commit),
    .i_br_upd         (br_upd),
    .o_freelist_ready (freelist_ready),
    .o_disp           (disp)
  );

  // --------------------------------------------------
  // stimulus line handling
  // --------------------------------------------------
  function automatic void split_fields(input string s);
    string tok;
    byte   c;
    fields = {};
    tok    = "";
    for (int pos = 0; pos <= s.len(); pos++) begin
      c = (pos < s.len()) ? s.getc(pos) : " ";
      if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
        if (tok.len() > 0) begin
          fields.push_back(tok.atohex());
        end
        tok = "";
      end else begin
        tok = {tok, s.substr(pos, pos)};
      end
    end
  endfunction

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!freelist_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!freelist_ready) begin
      $display("Timeout on line %0d, o_freelist_ready stayed low", line_no);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // one dispatch group, fired or only looked up, checked before the edge
  task automatic replay_group(input logic fire);
    int    exp_id [`RN_DISP_SIZE][4];
    rnid_t got [4];
    int    b;
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      for (int k = 0; k < 4; k++) begin
        exp_id[d][k] = fields[1 + 9 * `RN_DISP_SIZE + 4 * d + k];
      end
    end
    for (int r = 0; r < fields[0] && !aborted; r++) begin
      if (fire) begin
        wait_ready();
      end
      if (!aborted) begin
        for (int d = 0; d < `RN_DISP_SIZE; d++) begin
          b = 1 + 9 * d;
          front[d].valid     = (fields[b] != 0);
          front[d].wr_en     = (fields[b + 1] != 0);
          front[d].rd        = arch_id_t'(fields[b + 2]);
          front[d].rs1_valid = (fields[b + 3] != 0);
          front[d].rs1       = arch_id_t'(fields[b + 4]);
          front[d].rs2_valid = (fields[b + 5] != 0);
          front[d].rs2       = arch_id_t'(fields[b + 6]);
          front[d].is_br     = (fields[b + 7] != 0);
          brtag[d]           = brtag_t'(fields[b + 8]);
        end
        front_fire = fire;
        #1;
        for (int d = 0; d < `RN_DISP_SIZE; d++) begin
          checks++;
          if (disp[d].valid !== front[d].valid) begin
            errors++;
            $display("Mismatch o_disp[%0d].valid: got 0x%h expected 0x%h (line %0d)",
                     d, disp[d].valid, front[d].valid, line_no);
          end
          got[0] = disp[d].rd_id;
          got[1] = disp[d].old_id;
          got[2] = disp[d].rs1_id;
          got[3] = disp[d].rs2_id;
          for (int k = 0; k < 4; k++) begin
            checks++;
            if (got[k] !== rnid_t'(exp_id[d][k])) begin
              errors++;
              $display("Mismatch o_disp[%0d].%s: got 0x%h expected 0x%h (line %0d)",
                       d, id_names[k], got[k], rnid_t'(exp_id[d][k]), line_no);
            end
          end
        end
        @(negedge clk);
        front_fire = 1'b0;
        // a repeat rewrites rd, so the last new id becomes the old one
        for (int d = 0; d < `RN_DISP_SIZE; d++) begin
          if (exp_id[d][0] != 0) begin
            exp_id[d][1] = exp_id[d][0];
            exp_id[d][0]++;
          end
        end
      end
    end
  endtask

  task automatic issue_commit();
    logic [LANE_W-1:0] lane;
    lane                = LANE_W'(fields[0]);
    commit[lane].valid  = 1'b1;
    commit[lane].kind   = (fields[1] != 0) ? CMT_DEAD : CMT_LIVE;
    commit[lane].rd     = arch_id_t'(fields[2]);
    commit[lane].new_id = rnid_t'(fields[3]);
    commit[lane].old_id = rnid_t'(fields[4]);
    @(negedge clk);
    commit[lane] = '0;
  endtask

  task automatic apply_branch_update();
    br_upd.valid      = (fields[0] != 0);
    br_upd.mispredict = (fields[1] != 0);
    br_upd.dead       = (fields[2] != 0);
    br_upd.tag        = brtag_t'(fields[3]);
    @(negedge clk);
    br_upd = '0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int    fd;
    int    waited;
    string line;
    byte   op;
    logic  bad;
    errors     = 0;
    checks     = 0;
    line_no    = 0;
    aborted    = 1'b0;
    fd         = 0;
    front_fire = 1'b0;
    br_upd     = '0;
    for (int d = 0; d < `RN_DISP_SIZE; d++) begin
      front[d]  = '0;
      brtag[d]  = '0;
      commit[d] = '0;
    end

    waited = 0;
    while (reset_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (reset_n !== 1'b1) begin
      $display("Reset was never released");
      errors++;
      aborted = 1'b1;
    end else begin
      for (int d = 0; d < `RN_DISP_SIZE; d++) begin
        checks++;
        if (disp[d].valid !== 1'b0) begin
          errors++;
          $display("Mismatch o_disp[%0d].valid: got 0x%h expected 0x0 after reset",
                   d, disp[d].valid);
        end
      end
      fd = $fopen("rename_stimulus.txt", "r");
      if (fd == 0) begin
        $display("Could not open rename_stimulus.txt");
        errors++;
        aborted = 1'b1;
      end
    end

    while (!aborted && $fgets(line, fd) > 0) begin
      line_no++;
      if (line.len() > 1 && line.getc(0) != "#") begin
        op  = line.getc(0);
        bad = 1'b0;
        split_fields(line.substr(1, line.len() - 1));
        case (op)
          "F", "L": begin
            if (fields.size() != GROUP_COLS) bad = 1'b1;
            else replay_group(op == "F");
          end
          "C": begin
            if (fields.size() != 5) bad = 1'b1;
            else issue_commit();
          end
          "B": begin
            if (fields.size() != 4) bad = 1'b1;
            else apply_branch_update();
          end
          "R": begin
            checks++;
            if (fields.size() != 1) begin
              bad = 1'b1;
            end else if (freelist_ready !== (fields[0] != 0)) begin
              errors++;
              $display("Mismatch o_freelist_ready: got 0x%h expected 0x%h (line %0d)",
                       freelist_ready, (fields[0] != 0), line_no);
            end
          end
          default: bad = 1'b1;
        endcase
        if (bad) begin
          $display("Stimulus line %0d could not be understood", line_no);
          errors++;
          aborted = 1'b1;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("rename_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rename_stimulus.txt
# F fire, L look-up: rep, per lane v we rd r1v rs1 r2v rs2 br tag, per lane exp rd old rs1 rs2
# C commit: lane kind(0 live, 1 dead) rd new old; B branch: valid mispred dead tag; R ready
# all columns hex; a repeated group rewrites rd and expects the next id, the last id as old
R 1
# first group, then in-group bypass on x7
F 1  1 1 05 1 01 0 00 0 0  1 1 06 1 02 0 00 0 0  20 05 01 00  30 06 02 00
F 1  1 1 07 1 05 0 00 0 0  1 1 07 1 07 1 06 0 0  21 07 20 00  31 21 21 30
# x0 write pops nothing on lane 0
F 1  1 1 00 1 07 0 00 0 0  1 1 08 1 00 0 00 0 0  00 00 31 00  32 08 00 00
F 1  1 1 09 0 00 0 00 0 0  0 0 00 0 00 0 00 0 0  22 09 00 00  00 00 00 00
# drain lane 0, then give ids back by live and dead commits
F d  1 1 0a 0 00 0 00 0 0  0 0 00 0 00 0 00 0 0  23 0a 00 00  00 00 00 00
R 0
C 0 0 0a 23 0a
C 0 1 0a 28 27
F 1  1 1 0b 0 00 0 00 0 0  0 0 00 0 00 0 00 0 0  0a 0b 00 00  00 00 00 00
F 1  1 1 0c 0 00 0 00 0 0  0 0 00 0 00 0 00 0 0  28 0c 00 00  00 00 00 00
C 0 0 09 22 09
C 0 0 0b 0a 0b
# branch with tag 1 on lane 1, then a group over the same registers
F 1  1 1 07 1 05 0 00 0 0  1 1 08 1 07 1 06 1 1  09 31 20 00  33 32 09 30
F 1  1 1 07 0 00 0 00 0 0  1 1 08 0 00 0 00 0 0  0b 09 00 00  34 33 00 00
# correct prediction and dead branch keep the map, a mispredict restores it
B 1 0 0 1
L 1  1 0 00 1 07 1 08 0 0  0 0 00 0 00 0 00 0 0  00 00 0b 34  00 00 00 00
B 1 1 1 1
L 1  1 0 00 1 07 1 08 0 0  0 0 00 0 00 0 00 0 0  00 00 0b 34  00 00 00 00
B 1 1 0 1
L 1  1 0 00 1 07 1 08 0 0  0 0 00 0 00 0 00 0 0  00 00 09 33  00 00 00 00

// File: list.f
+incdir+.
rename_types_pkg.sv
rename_event_pkg.sv
rename_freelist.sv
rename_map_table.sv
rename_snapshot_queue.sv
rename_dep_bypass.sv
rename_unit.sv
rename_tb_clock.sv
rename_tb.sv

// File: Makefile
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
